//--- rtl/i2c_pkg.sv
package i2c_pkg;

    // drive levels of the open-drain pair, 1 means released
    typedef struct packed {
        logic sda;
        logic scl;
    } t_line;

    localparam t_line LINE_RELEASED = '{sda: 1'b1, scl: 1'b1};

    // shared by both generators so their state reads alike in waveforms
    typedef enum logic [2:0] {
        PH_IDLE     = 3'd0,
        PH_WAIT     = 3'd1,
        PH_SDA_LOW  = 3'd2,
        PH_SCL_HIGH = 3'd3,
        PH_SDA_HIGH = 3'd4,
        PH_DONE     = 3'd5
    } t_gen_phase;

    // clock cycles in a quarter of the i2c bit period
    function automatic int quarter_cycles(input int clk_freq, input int i2c_freq);
        int q;
        q = clk_freq / (4 * i2c_freq);
        return (q < 1) ? 1 : q;
    endfunction

endpackage

//--- rtl/i2c_cond_if.sv
`timescale 1ns/1ps

interface i2c_cond_if;
    import i2c_pkg::*;

    logic  req;
    logic  grant;
    logic  ready;
    logic  done;
    logic  busy;
    t_line drive;

    modport gen (
        input  req,
        input  grant,
        output ready,
        output done,
        output busy,
        output drive
    );

    modport arb (
        input  ready,
        input  busy,
        input  drive,
        output grant
    );

endinterface

//--- rtl/i2c_start_gen.sv
`timescale 1ns/1ps

module i2c_start_gen #(
    parameter int CLK_FREQ = 4_000_000,
    parameter int I2C_FREQ = 100_000
) (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_sda,
    input  logic       i_scl,
    i2c_cond_if.gen    bus
);
    import i2c_pkg::*;

    localparam int Q     = quarter_cycles(CLK_FREQ, I2C_FREQ);
    localparam int CNT_W = $clog2(Q + 1);

    t_gen_phase       phase;
    t_gen_phase       phase_ret;
    t_line            drive_q;
    logic [CNT_W-1:0] cnt;
    logic             accept;

    // only start on a free bus, both lines high
    assign bus.ready = (phase == PH_IDLE) && i_sda && i_scl;
    assign bus.done  = (phase == PH_DONE);
    assign bus.busy  = (phase != PH_IDLE);
    assign bus.drive = drive_q;

    assign accept = bus.req && bus.ready && bus.grant;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            phase     <= PH_IDLE;
            phase_ret <= PH_IDLE;
            drive_q   <= LINE_RELEASED;
            cnt       <= '0;
        end else begin
            case (phase)
                PH_IDLE: begin
                    drive_q <= LINE_RELEASED;
                    if (accept) begin
                        phase <= PH_SDA_LOW;
                    end
                end
                PH_SDA_LOW: begin
                    // sda falls while scl is still released
                    drive_q.sda <= 1'b0;
                    cnt         <= CNT_W'(Q);
                    phase_ret   <= PH_SCL_HIGH;
                    phase       <= PH_WAIT;
                end
                PH_SCL_HIGH: begin
                    // end of start hold time, take the clock low
                    drive_q.scl <= 1'b0;
                    cnt         <= CNT_W'(Q);
                    phase_ret   <= PH_DONE;
                    phase       <= PH_WAIT;
                end
                PH_WAIT: begin
                    if (cnt == '0) begin
                        phase <= phase_ret;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                PH_DONE: begin
                    phase <= PH_IDLE;
                end
                default: begin
                    phase <= PH_IDLE;
                end
            endcase
        end
    end

endmodule

//--- rtl/i2c_stop_gen.sv
`timescale 1ns/1ps

module i2c_stop_gen #(
    parameter int CLK_FREQ = 4_000_000,
    parameter int I2C_FREQ = 100_000
) (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_sda,
    input  logic       i_scl,
    i2c_cond_if.gen    bus
);
    import i2c_pkg::*;

    localparam int Q     = quarter_cycles(CLK_FREQ, I2C_FREQ);
    localparam int CNT_W = $clog2(Q + 1);

    t_gen_phase       phase;
    t_gen_phase       phase_ret;
    t_line            drive_q;
    logic [CNT_W-1:0] cnt;
    logic             accept;

    // a stop only makes sense once the clock is low
    assign bus.ready = (phase == PH_IDLE) && !i_scl;
    assign bus.done  = (phase == PH_DONE);
    assign bus.busy  = (phase != PH_IDLE);
    assign bus.drive = drive_q;

    assign accept = bus.req && bus.ready && bus.grant;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            phase     <= PH_IDLE;
            phase_ret <= PH_IDLE;
            drive_q   <= LINE_RELEASED;
            cnt       <= '0;
        end else begin
            case (phase)
                PH_IDLE: begin
                    // follow the line so taking over causes no glitch
                    drive_q.sda <= i_sda;
                    drive_q.scl <= i_scl;
                    if (accept) begin
                        drive_q.scl <= 1'b0;
                        phase       <= PH_SDA_LOW;
                    end
                end
                PH_SDA_LOW: begin
                    drive_q.sda <= 1'b0;
                    cnt         <= CNT_W'(Q);
                    phase_ret   <= PH_SCL_HIGH;
                    phase       <= PH_WAIT;
                end
                PH_SCL_HIGH: begin
                    // release scl and re-wait while a slave stretches it
                    drive_q.scl <= 1'b1;
                    cnt         <= CNT_W'(Q);
                    phase_ret   <= PH_SCL_HIGH;
                    phase       <= i_scl ? PH_SDA_HIGH : PH_WAIT;
                end
                PH_SDA_HIGH: begin
                    // sda rises with scl high, this is the stop itself
                    drive_q.sda <= 1'b1;
                    cnt         <= CNT_W'(Q);
                    phase_ret   <= PH_DONE;
                    phase       <= PH_WAIT;
                end
                PH_WAIT: begin
                    if (cnt == '0) begin
                        phase <= phase_ret;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                PH_DONE: begin
                    phase <= PH_IDLE;
                end
                default: begin
                    phase <= PH_IDLE;
                end
            endcase
        end
    end

endmodule

//--- rtl/i2c_line_arbiter.sv
`timescale 1ns/1ps

module i2c_line_arbiter (
    input  logic       i_clk,
    input  logic       i_rst,
    i2c_cond_if.arb    start_bus,
    i2c_cond_if.arb    stop_bus,
    output logic       o_sda_drive,
    output logic       o_scl_drive
);
    import i2c_pkg::*;

    t_line last_q;
    t_line sel;

    // start has priority, a ready start keeps the stop from being granted
    assign start_bus.grant = !stop_bus.busy;
    assign stop_bus.grant  = !start_bus.busy && !start_bus.ready;

    always_comb begin
        if (start_bus.busy) begin
            sel = start_bus.drive;
        end else if (stop_bus.busy) begin
            sel = stop_bus.drive;
        end else begin
            // nobody owns the bus, keep the line where it was left
            sel = last_q;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            last_q <= LINE_RELEASED;
        end else if (start_bus.busy || stop_bus.busy) begin
            last_q <= sel;
        end
    end

    assign o_sda_drive = sel.sda;
    assign o_scl_drive = sel.scl;

endmodule

//--- rtl/i2c_cond_top.sv
`timescale 1ns/1ps

module i2c_cond_top #(
    parameter int CLK_FREQ = 4_000_000,
    parameter int I2C_FREQ = 100_000
) (
    input  logic i_clk,
    input  logic i_rst,

    input  logic i_start_req,
    input  logic i_stop_req,

    // sampled bus lines
    input  logic i_sda,
    input  logic i_scl,

    output logic o_start_ready,
    output logic o_start_done,
    output logic o_stop_ready,
    output logic o_stop_done,

    // drive levels, 1 means released
    output logic o_sda_drive,
    output logic o_scl_drive
);

    i2c_cond_if start_if ();
    i2c_cond_if stop_if ();

    assign start_if.req  = i_start_req;
    assign stop_if.req   = i_stop_req;

    assign o_start_ready = start_if.ready;
    assign o_start_done  = start_if.done;
    assign o_stop_ready  = stop_if.ready;
    assign o_stop_done   = stop_if.done;

    i2c_start_gen #(
        .CLK_FREQ (CLK_FREQ),
        .I2C_FREQ (I2C_FREQ)
    ) u_start_gen (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_sda (i_sda),
        .i_scl (i_scl),
        .bus   (start_if.gen)
    );

    i2c_stop_gen #(
        .CLK_FREQ (CLK_FREQ),
        .I2C_FREQ (I2C_FREQ)
    ) u_stop_gen (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_sda (i_sda),
        .i_scl (i_scl),
        .bus   (stop_if.gen)
    );

    i2c_line_arbiter u_arbiter (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .start_bus   (start_if.arb),
        .stop_bus    (stop_if.arb),
        .o_sda_drive (o_sda_drive),
        .o_scl_drive (o_scl_drive)
    );

endmodule

//--- verif/i2c_cond_sva.sv
`timescale 1ns/1ps

module i2c_cond_sva (
    input logic i_clk,
    input logic i_rst,
    input logic i_start_req,
    input logic i_stop_req,
    input logic i_scl,
    input logic o_start_ready,
    input logic o_start_done,
    input logic o_stop_ready,
    input logic o_stop_done,
    input logic o_sda_drive,
    input logic o_scl_drive
);

    int unsigned fail_count = 0;

    // request seen with ready high on the previous edge
    logic start_offer_q;
    logic stop_offer_q;
    // accepted and not yet past its done pulse
    logic start_act;
    logic stop_act;
    logic start_acc;
    logic stop_acc;

    // acceptance shows as ready dropping while a request was pending
    assign start_acc = start_offer_q && !o_start_ready;
    assign stop_acc  = stop_offer_q && !o_stop_ready;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            start_offer_q <= 1'b0;
            stop_offer_q  <= 1'b0;
            start_act     <= 1'b0;
            stop_act      <= 1'b0;
        end else begin
            start_offer_q <= i_start_req && o_start_ready;
            stop_offer_q  <= i_stop_req && o_stop_ready;
            if (start_acc) begin
                start_act <= 1'b1;
            end else if (o_start_done) begin
                start_act <= 1'b0;
            end
            if (stop_acc) begin
                stop_act <= 1'b1;
            end else if (o_stop_done) begin
                stop_act <= 1'b0;
            end
        end
    end

    // start shape: sda falls only with scl high, scl falls only after sda
    a_sda_fall: assert property (@(posedge i_clk) disable iff (i_rst)
        $fell(o_sda_drive) |-> i_scl && o_scl_drive)
    else begin
        $error("sda fell while scl was low");
        fail_count++;
    end
    a_scl_fall: assert property (@(posedge i_clk) disable iff (i_rst)
        $fell(o_scl_drive) |-> !o_sda_drive)
    else begin
        $error("scl fell before sda");
        fail_count++;
    end
    a_start_end: assert property (@(posedge i_clk) disable iff (i_rst)
        o_start_done |-> !o_scl_drive)
    else begin
        $error("scl not held low at start done");
        fail_count++;
    end

    // stop shape, sda never rises while a slave stretches scl
    a_sda_rise: assert property (@(posedge i_clk) disable iff (i_rst)
        $rose(o_sda_drive) |-> i_scl)
    else begin
        $error("sda rose while scl was low");
        fail_count++;
    end
    a_stop_end: assert property (@(posedge i_clk) disable iff (i_rst)
        o_stop_done |-> o_sda_drive && i_scl)
    else begin
        $error("bus not released at stop done");
        fail_count++;
    end

    // done pulses and ready
    a_start_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        o_start_done |=> !o_start_done)
    else begin
        $error("start done longer than one cycle");
        fail_count++;
    end
    a_stop_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        o_stop_done |=> !o_stop_done)
    else begin
        $error("stop done longer than one cycle");
        fail_count++;
    end
    a_start_rdy: assert property (@(posedge i_clk) disable iff (i_rst)
        start_act |-> !o_start_ready)
    else begin
        $error("start ready high while active");
        fail_count++;
    end
    a_stop_rdy: assert property (@(posedge i_clk) disable iff (i_rst)
        stop_act |-> !o_stop_ready)
    else begin
        $error("stop ready high while active");
        fail_count++;
    end

    // only one generator can own the bus
    a_start_excl: assert property (@(posedge i_clk) disable iff (i_rst)
        (start_acc || start_act) |-> !o_stop_done && !stop_acc)
    else begin
        $error("stop accepted or done while the start was active");
        fail_count++;
    end
    a_stop_excl: assert property (@(posedge i_clk) disable iff (i_rst)
        (stop_acc || stop_act) |-> !o_start_done && !start_acc)
    else begin
        $error("start accepted or done while the stop was active");
        fail_count++;
    end

    a_reset: assert property (@(posedge i_clk)
        $fell(i_rst) |-> o_sda_drive && o_scl_drive && !o_start_done && !o_stop_done)
    else begin
        $error("outputs not idle after reset");
        fail_count++;
    end

endmodule

bind i2c_cond_top i2c_cond_sva u_sva (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_start_req   (i_start_req),
    .i_stop_req    (i_stop_req),
    .i_scl         (i_scl),
    .o_start_ready (o_start_ready),
    .o_start_done  (o_start_done),
    .o_stop_ready  (o_stop_ready),
    .o_stop_done   (o_stop_done),
    .o_sda_drive   (o_sda_drive),
    .o_scl_drive   (o_scl_drive)
);

//--- verif/i2c_cond_tb.sv
`timescale 1ns/1ps

module i2c_cond_tb;

    localparam int CLK_FREQ = 4_000_000;
    localparam int I2C_FREQ = 100_000;
    localparam int Q        = CLK_FREQ / (4 * I2C_FREQ);
    localparam int N_PAIRS  = 11;
    localparam int WD_CYCLES = N_PAIRS * (4 * Q + 50) * 2;

    logic i_clk = 1'b0;
    logic i_rst = 1'b1;
    logic i_start_req = 1'b0;
    logic i_stop_req = 1'b0;
    logic i_sda = 1'b1;
    logic i_scl = 1'b1;
    logic o_start_ready;
    logic o_start_done;
    logic o_stop_ready;
    logic o_stop_done;
    logic o_sda_drive;
    logic o_scl_drive;

    integer seed = 37;
    int     stretch_len = 0;
    int     stretch_cnt = 0;
    logic   stretching;

    i2c_cond_top #(
        .CLK_FREQ (CLK_FREQ),
        .I2C_FREQ (I2C_FREQ)
    ) i_dut (.*);

    always #5 i_clk = ~i_clk;

    // open-drain bus, the slave only holds scl low after a release
    always @(negedge i_clk) begin
        stretching = 1'b0;
        if (!o_scl_drive) begin
            stretch_cnt = stretch_len;
        end else if (stretch_cnt > 0) begin
            stretch_cnt = stretch_cnt - 1;
            stretching  = 1'b1;
        end
        i_sda <= o_sda_drive;
        i_scl <= o_scl_drive && !stretching;
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped");
    endtask

    // assertion failures are counted in the bound checker
    always @(negedge i_clk) begin
        if (i_dut.u_sva.fail_count != 0) begin
            report_fail("an assertion on the DUT ports failed");
        end
    end

    initial begin
        #(WD_CYCLES * 10);
        report_fail("timeout: the DUT never finished its transactions");
    end

    task automatic run_start();
        @(negedge i_clk);
        i_start_req = 1'b1;
        do @(negedge i_clk); while (!o_start_done);
        i_start_req = 1'b0;
    endtask

    task automatic run_stop(input int stretch);
        stretch_len = stretch;
        @(negedge i_clk);
        i_stop_req = 1'b1;
        do @(negedge i_clk); while (!o_stop_done);
        i_stop_req = 1'b0;
    endtask

    // both drives must stay put while nobody owns the bus
    task automatic check_hold(input int cycles);
        logic sda_ref;
        logic scl_ref;
        sda_ref = o_sda_drive;
        scl_ref = o_scl_drive;
        repeat (cycles) begin
            @(negedge i_clk);
            if (o_sda_drive !== sda_ref) begin
                $display("error at %0t: o_sda_drive expected %b got %b",
                         $time, sda_ref, o_sda_drive);
                report_fail("line hold broken");
            end
            if (o_scl_drive !== scl_ref) begin
                $display("error at %0t: o_scl_drive expected %b got %b",
                         $time, scl_ref, o_scl_drive);
                report_fail("line hold broken");
            end
        end
    endtask

    initial begin
        int i;
        repeat (3) @(negedge i_clk);
        i_rst = 1'b0;
        check_hold(4);

        for (i = 0; i < 8; i++) begin
            run_start();
            check_hold(3);
            // every other stop gets a stretching slave
            run_stop((i % 2 == 1) ? int'($unsigned($random(seed)) % 41) : 0);
            check_hold(3);
        end

        // simultaneous requests, start must win
        @(negedge i_clk);
        stretch_len = 0;
        i_start_req = 1'b1;
        i_stop_req  = 1'b1;
        do begin
            @(negedge i_clk);
            if (o_stop_done) begin
                report_fail("stop finished before the start it raced");
            end
        end while (!o_start_done);
        i_start_req = 1'b0;
        do @(negedge i_clk); while (!o_stop_done);
        i_stop_req = 1'b0;
        check_hold(3);

        // start requested while the stop owns the bus
        run_start();
        @(negedge i_clk);
        stretch_len = 12;
        i_stop_req = 1'b1;
        repeat (5) @(negedge i_clk);
        i_start_req = 1'b1;
        do @(negedge i_clk); while (!o_stop_done);
        i_stop_req = 1'b0;
        do @(negedge i_clk); while (!o_start_done);
        i_start_req = 1'b0;
        run_stop(0);
        check_hold(3);

        if (i_dut.u_sva.fail_count != 0) begin
            report_fail("an assertion on the DUT ports failed");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

//--- vlog.f
rtl/i2c_pkg.sv
rtl/i2c_cond_if.sv
rtl/i2c_start_gen.sv
rtl/i2c_stop_gen.sv
rtl/i2c_line_arbiter.sv
rtl/i2c_cond_top.sv
verif/i2c_cond_sva.sv
verif/i2c_cond_tb.sv

//--- run.sh
#!/bin/sh
# build and run the I2C condition testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module i2c_cond_tb -f vlog.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
